//--- Bender.yml
package:
  name: x68k_glue

sources:
  - source/x68k_glue_pkg.sv
  - source/x68k_status_regs.sv
  - source/x68k_reset_loader.sv
  - source/x68k_audio_mix.sv
  - source/x68k_mt32_display.sv
  - source/x68k_glue_top.sv
  - target: test
    files:
      - verification/x68k_glue_sva.sv
      - verification/x68k_glue_tb.sv

//--- source/x68k_audio_mix.sv
`default_nettype none

module x68k_audio_mix (
	input  wire                     clk_sys,
	input  wire                     rst_n,
	input  x68k_glue_pkg::sample_t  core_l,
	input  x68k_glue_pkg::sample_t  core_r,
	input  x68k_glue_pkg::sample_t  mt32_l,
	input  x68k_glue_pkg::sample_t  mt32_r,
	input  wire                     mt32_available,
	input  wire                     mt32_disable,
	input  wire                     comp_sel,
	output x68k_glue_pkg::sample_t  audio_l,
	output x68k_glue_pkg::sample_t  audio_r
);

	// Add two samples and clamp to the 16-bit range
	function automatic x68k_glue_pkg::sample_t sat_add(
		input x68k_glue_pkg::sample_t a,
		input x68k_glue_pkg::sample_t b
	);
		logic signed [16:0] sum;
		sum = {a[15], a} + {b[15], b};
		// Top two bits differ on overflow
		if (sum[16] != sum[15]) begin
			return {sum[16], {15{~sum[16]}}};
		end
		return sum[15:0];
	endfunction

	// Two-segment compression on magnitude with the sign put back after
	function automatic x68k_glue_pkg::sample_t compress(
		input x68k_glue_pkg::sample_t s,
		input logic                   sel
	);
		logic [15:0] mag;
		logic [15:0] res;
		mag = s[15] ? 16'(~s + 16'd1) : 16'(s);
		if (!sel) begin
			res = (mag < x68k_glue_pkg::COMP_X1) ? 16'(mag * x68k_glue_pkg::COMP_A1) :
				16'((mag - x68k_glue_pkg::COMP_X1) / x68k_glue_pkg::COMP_F1
				+ x68k_glue_pkg::COMP_B1);
		end else begin
			res = (mag < x68k_glue_pkg::COMP_X2) ? 16'(mag * x68k_glue_pkg::COMP_A2) :
				16'((mag - x68k_glue_pkg::COMP_X2) / x68k_glue_pkg::COMP_F2
				+ x68k_glue_pkg::COMP_B2);
		end
		// Top of the curve lands a few counts past full scale
		if (res > 16'd32767) begin
			res = 16'd32767;
		end
		return s[15] ? x68k_glue_pkg::sample_t'(~res + 16'd1) : x68k_glue_pkg::sample_t'(res);
	endfunction

	// Synth muted by the menu while it is present
	logic                   mute;
	x68k_glue_pkg::sample_t syn_l;
	x68k_glue_pkg::sample_t syn_r;

	// Stage 1 results
	x68k_glue_pkg::sample_t mix_l;
	x68k_glue_pkg::sample_t mix_r;
	// Curve select travels with its sample pair
	logic                   mix_sel;

	assign mute  = mt32_available & mt32_disable;
	assign syn_l = mute ? '0 : mt32_l;
	assign syn_r = mute ? '0 : mt32_r;

	////////////////////////////////////////////////////////////////////////////
	// Stage 1 mix and stage 2 compress
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			mix_l   <= '0;
			mix_r   <= '0;
			mix_sel <= 1'b0;
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			mix_l   <= sat_add(core_l, syn_l);
			mix_r   <= sat_add(core_r, syn_r);
			mix_sel <= comp_sel;
			audio_l <= compress(mix_l, mix_sel);
			audio_r <= compress(mix_r, mix_sel);
		end
	end

endmodule

`default_nettype wire

//--- source/x68k_glue_pkg.sv
`default_nettype none

package x68k_glue_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Shared types
	////////////////////////////////////////////////////////////////////////////

	// Menu status word from the host
	typedef logic [63:0] status_t;
	// Signed PCM sample
	typedef logic signed [15:0] sample_t;
	// One video colour channel
	typedef logic [7:0] chan_t;
	// Mode, ROM or soundfont byte reported by the synth
	typedef logic [7:0] mt32_code_t;
	// Index into the menu info message list
	typedef logic [3:0] info_code_t;

	// Show Info policy from the menu
	typedef enum logic [1:0] {
		INFO_OFF       = 2'd0,
		INFO_ON_CHANGE = 2'd1,
		INFO_LCD_ON    = 2'd2,
		INFO_LCD_AUTO  = 2'd3
	} info_mode_e;

	// Status word bit positions
	localparam int ST_RESET        = 0;
	localparam int ST_MT32_DISABLE = 18;
	localparam int ST_COMP_SEL     = 21;
	localparam int ST_MT32_RESET   = 40;
	// Low bit of the two-bit info policy field
	localparam int ST_INFO_LO      = 41;

	// Synth mode codes
	localparam logic [7:0] MT32_MODE_ROM = 8'hA1;
	localparam logic [7:0] MT32_MODE_SF  = 8'hA2;

	// Info message indices
	localparam logic [3:0] INFO_SF_BASE  = 4'd1;
	localparam logic [3:0] INFO_ROM_BASE = 4'd9;
	localparam logic [3:0] INFO_UNKNOWN  = 4'd12;

	// LCD hold time in clk_sys cycles
	localparam logic [31:0] LCD_HOLD_DEFAULT = 32'd180_000_000;

	////////////////////////////////////////////////////////////////////////////
	// Compressor curves
	////////////////////////////////////////////////////////////////////////////

	// Soft curve
	localparam logic [15:0] COMP_A1 = 16'd2;
	localparam logic [15:0] COMP_F1 = 16'd4;
	localparam logic [15:0] COMP_X1 = 16'((32767 * (COMP_F1 - 1)) / (COMP_F1 * COMP_A1 - 1) + 1);
	localparam logic [15:0] COMP_B1 = 16'(COMP_X1 * COMP_A1);

	// Hard curve
	localparam logic [15:0] COMP_A2 = 16'd4;
	localparam logic [15:0] COMP_F2 = 16'd8;
	localparam logic [15:0] COMP_X2 = 16'((32767 * (COMP_F2 - 1)) / (COMP_F2 * COMP_A2 - 1) + 1);
	localparam logic [15:0] COMP_B2 = 16'(COMP_X2 * COMP_A2);

endpackage

`default_nettype wire

//--- source/x68k_glue_top.sv
`default_nettype none

module x68k_glue_top #(
	parameter logic [31:0] LCD_HOLD = x68k_glue_pkg::LCD_HOLD_DEFAULT
) (
	input  wire                        clk_sys,
	input  wire                        rst_n,
	// Host menu
	input  x68k_glue_pkg::status_t     status,
	input  wire                        user_button,
	// Host download
	input  wire                        ioctl_download,
	input  wire                        ioctl_wr,
	output logic                       ioctl_wait,
	// Core loader and reset
	input  wire                        ldr_ack,
	output logic                       ldr_wr,
	output logic                       ldr_aen,
	output logic                       ldr_done,
	output logic                       core_rst_n,
	// Audio
	input  x68k_glue_pkg::sample_t     core_l,
	input  x68k_glue_pkg::sample_t     core_r,
	input  x68k_glue_pkg::sample_t     mt32_l,
	input  x68k_glue_pkg::sample_t     mt32_r,
	output x68k_glue_pkg::sample_t     audio_l,
	output x68k_glue_pkg::sample_t     audio_r,
	// Synth status and LCD
	input  wire                        mt32_available,
	input  wire                        mt32_newmode,
	input  x68k_glue_pkg::mt32_code_t  mt32_mode,
	input  x68k_glue_pkg::mt32_code_t  mt32_rom,
	input  x68k_glue_pkg::mt32_code_t  mt32_sf,
	input  wire                        lcd_update,
	input  wire                        lcd_en,
	input  wire                        lcd_pix,
	output logic                       mt32_rst,
	output logic                       info_req,
	output x68k_glue_pkg::info_code_t  info_disp,
	// Video
	input  x68k_glue_pkg::chan_t       red_in,
	input  x68k_glue_pkg::chan_t       green_in,
	input  x68k_glue_pkg::chan_t       blue_in,
	output x68k_glue_pkg::chan_t       red,
	output x68k_glue_pkg::chan_t       green,
	output x68k_glue_pkg::chan_t       blue
);

	// Decoded status fields
	logic                      reset_req;
	logic                      init_done;
	logic                      mt32_disable;
	logic                      comp_sel;
	x68k_glue_pkg::info_mode_e info_mode;

	x68k_status_regs u_status (
		.clk_sys, .rst_n, .status, .user_button,
		.reset_req, .init_done, .mt32_disable, .comp_sel, .mt32_rst, .info_mode
	);

	x68k_reset_loader u_loader (
		.clk_sys, .rst_n, .reset_req, .init_done,
		.ioctl_download, .ioctl_wr, .ldr_ack,
		.core_rst_n, .ldr_wr, .ldr_aen, .ldr_done
	);

	// Host holds its next byte while the core write is pending
	assign ioctl_wait = ldr_wr;

	x68k_audio_mix u_audio (
		.clk_sys, .rst_n, .core_l, .core_r, .mt32_l, .mt32_r,
		.mt32_available, .mt32_disable, .comp_sel, .audio_l, .audio_r
	);

	x68k_mt32_display #(.LCD_HOLD(LCD_HOLD)) u_display (
		.clk_sys, .rst_n, .mt32_newmode, .lcd_update, .lcd_en, .lcd_pix,
		.mt32_mode, .mt32_rom, .mt32_sf, .info_mode,
		.red_in, .green_in, .blue_in,
		.info_req, .info_disp, .red, .green, .blue
	);

endmodule

`default_nettype wire

//--- source/x68k_mt32_display.sv
`default_nettype none

module x68k_mt32_display #(
	parameter logic [31:0] LCD_HOLD = x68k_glue_pkg::LCD_HOLD_DEFAULT
) (
	input  wire                        clk_sys,
	input  wire                        rst_n,
	input  wire                        mt32_newmode,
	input  wire                        lcd_update,
	input  wire                        lcd_en,
	input  wire                        lcd_pix,
	input  x68k_glue_pkg::mt32_code_t  mt32_mode,
	input  x68k_glue_pkg::mt32_code_t  mt32_rom,
	input  x68k_glue_pkg::mt32_code_t  mt32_sf,
	input  x68k_glue_pkg::info_mode_e  info_mode,
	input  x68k_glue_pkg::chan_t       red_in,
	input  x68k_glue_pkg::chan_t       green_in,
	input  x68k_glue_pkg::chan_t       blue_in,
	output logic                       info_req,
	output x68k_glue_pkg::info_code_t  info_disp,
	output x68k_glue_pkg::chan_t       red,
	output x68k_glue_pkg::chan_t       green,
	output x68k_glue_pkg::chan_t       blue
);

	// LCD pixel doubled into the two top bits of a channel
	function automatic x68k_glue_pkg::chan_t overlay(
		input x68k_glue_pkg::chan_t c,
		input logic                 pix
	);
		return {{2{pix}}, c[7:2]};
	endfunction

	logic        newmode_prev;
	logic        update_prev;
	logic        lcd_on;
	logic        lcd_show;
	// Cycles left before the auto LCD turns off
	logic [31:0] hold_cnt;

	////////////////////////////////////////////////////////////////////////////
	// Info message
	////////////////////////////////////////////////////////////////////////////

	// Message index from the current synth mode
	always_ff @(posedge clk_sys) begin
		if (mt32_mode == x68k_glue_pkg::MT32_MODE_SF) begin
			info_disp <= x68k_glue_pkg::INFO_SF_BASE + 4'(mt32_sf[2:0]);
		end else if (mt32_mode == x68k_glue_pkg::MT32_MODE_ROM && mt32_rom < 8'd3) begin
			info_disp <= x68k_glue_pkg::INFO_ROM_BASE + 4'(mt32_rom[1:0]);
		end else begin
			info_disp <= x68k_glue_pkg::INFO_UNKNOWN;
		end
	end

	// Pop the message on every mode change when the menu asks for it
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			newmode_prev <= 1'b0;
			info_req     <= 1'b0;
		end else begin
			newmode_prev <= mt32_newmode;
			info_req     <= (newmode_prev ^ mt32_newmode) &&
				(info_mode == x68k_glue_pkg::INFO_ON_CHANGE);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// LCD on/off
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			update_prev <= 1'b0;
			hold_cnt    <= '0;
			lcd_on      <= 1'b0;
		end else begin
			update_prev <= lcd_update;
			if (hold_cnt != '0) begin
				hold_cnt <= hold_cnt - 32'd1;
			end
			case (info_mode)
				x68k_glue_pkg::INFO_LCD_ON: lcd_on <= 1'b1;
				x68k_glue_pkg::INFO_LCD_AUTO: begin
					if (hold_cnt == '0) begin
						lcd_on <= 1'b0;
					end
					// Fresh LCD content restarts the hold time
					if (update_prev ^ lcd_update) begin
						lcd_on   <= 1'b1;
						hold_cnt <= LCD_HOLD;
					end
				end
				default: lcd_on <= 1'b0;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Video overlay
	////////////////////////////////////////////////////////////////////////////

	assign lcd_show = lcd_on & lcd_en;

	always_ff @(posedge clk_sys) begin
		red   <= lcd_show ? overlay(red_in, lcd_pix) : red_in;
		green <= lcd_show ? overlay(green_in, lcd_pix) : green_in;
		blue  <= lcd_show ? overlay(blue_in, lcd_pix) : blue_in;
	end

endmodule

`default_nettype wire

//--- source/x68k_reset_loader.sv
`default_nettype none

module x68k_reset_loader (
	input  wire  clk_sys,
	input  wire  rst_n,
	input  wire  reset_req,
	input  wire  init_done,
	input  wire  ioctl_download,
	input  wire  ioctl_wr,
	input  wire  ldr_ack,
	output logic core_rst_n,
	output logic ldr_wr,
	output logic ldr_aen,
	output logic ldr_done
);

	// Set once the first download starts
	logic boot_ok;
	// Previous levels for edge detect
	logic download_prev;
	logic ack_prev;

	logic download_rise;
	logic download_fall;
	logic ack_rise;

	assign download_rise = ioctl_download & ~download_prev;
	assign download_fall = download_prev & ~ioctl_download;
	assign ack_rise      = ldr_ack & ~ack_prev;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			download_prev <= 1'b0;
			ack_prev      <= 1'b0;
		end else begin
			download_prev <= ioctl_download;
			ack_prev      <= ldr_ack;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Core reset
	////////////////////////////////////////////////////////////////////////////

	// Core stays in reset until host init is done and a boot image has begun
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			boot_ok    <= 1'b0;
			core_rst_n <= 1'b0;
		end else begin
			if (download_rise) begin
				boot_ok <= 1'b1;
			end
			core_rst_n <= boot_ok & ~(reset_req | ~init_done);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Download write exchange
	////////////////////////////////////////////////////////////////////////////

	// Write strobe held until the core acknowledges the byte
	// A new host strobe wins over a same-cycle acknowledge
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ldr_wr <= 1'b0;
		end else begin
			if (ack_rise && ldr_wr) begin
				ldr_wr <= 1'b0;
			end
			if (ioctl_wr && !ldr_done) begin
				ldr_wr <= 1'b1;
			end
		end
	end

	// End of the first download closes the loader for good
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ldr_done <= 1'b0;
		end else if (download_fall) begin
			ldr_done <= 1'b1;
		end
	end

	// Address enable only while the first download runs
	assign ldr_aen = ioctl_download & ~ldr_done;

endmodule

`default_nettype wire

//--- source/x68k_status_regs.sv
`default_nettype none

module x68k_status_regs (
	input  wire                        clk_sys,
	input  wire                        rst_n,
	input  x68k_glue_pkg::status_t     status,
	input  wire                        user_button,
	output logic                       reset_req,
	output logic                       init_done,
	output logic                       mt32_disable,
	output logic                       comp_sel,
	output logic                       mt32_rst,
	output x68k_glue_pkg::info_mode_e  info_mode
);

	// Registered copy of the host word
	x68k_glue_pkg::status_t status_q;
	logic                   button_q;
	// Previous menu reset bit for falling edge detect
	logic                   st_reset_prev;

	////////////////////////////////////////////////////////////////////////////
	// Input registers
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			status_q      <= '0;
			button_q      <= 1'b0;
			st_reset_prev <= 1'b0;
		end else begin
			status_q      <= status;
			button_q      <= user_button;
			st_reset_prev <= status_q[x68k_glue_pkg::ST_RESET];
		end
	end

	// First release of the menu reset marks the end of host init
	// Sticky until the next rst_n
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			init_done <= 1'b0;
		end else if (st_reset_prev && !status_q[x68k_glue_pkg::ST_RESET]) begin
			init_done <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Field decode
	////////////////////////////////////////////////////////////////////////////

	// Menu reset or the board button
	assign reset_req = status_q[x68k_glue_pkg::ST_RESET] | button_q;

	assign mt32_disable = status_q[x68k_glue_pkg::ST_MT32_DISABLE];
	assign comp_sel     = status_q[x68k_glue_pkg::ST_COMP_SEL];

	// Synth reset also follows any core reset request
	assign mt32_rst = status_q[x68k_glue_pkg::ST_MT32_RESET] | reset_req;

	assign info_mode = x68k_glue_pkg::info_mode_e'(status_q[x68k_glue_pkg::ST_INFO_LO +: 2]);

endmodule

`default_nettype wire

//--- verification/x68k_glue_sva.sv
`default_nettype none

module x68k_glue_sva (
	input wire clk_sys,
	input wire rst_n,
	input wire reset_req,
	input wire core_rst_n,
	input wire ldr_wr,
	input wire ldr_done
);

	timeunit 1ns;
	timeprecision 1ps;

	// Count of failed assertions
	int n_fail = 0;

	////////////////////////////////////////////////////////////////////////////
	// Loader exchange
	////////////////////////////////////////////////////////////////////////////

	// A finished download never starts a new core write
	ldr_wr_after_done: assert property (@(posedge clk_sys) disable iff (!rst_n)
		$rose(ldr_wr) |-> !$past(ldr_done))
		else begin
			n_fail++;
			$error("ldr_wr rose while ldr_done was already set");
		end

	// Done is sticky until the next board reset
	ldr_done_sticky: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!$fell(ldr_done))
		else begin
			n_fail++;
			$error("ldr_done fell without a reset");
		end

	////////////////////////////////////////////////////////////////////////////
	// Core reset
	////////////////////////////////////////////////////////////////////////////

	// core_rst_n is registered, so it follows a request one cycle later
	core_held_in_reset: assert property (@(posedge clk_sys) disable iff (!rst_n)
		reset_req |=> !core_rst_n)
		else begin
			n_fail++;
			$error("core_rst_n stayed high during a reset request");
		end

endmodule

// Watch every loader instance
bind x68k_reset_loader x68k_glue_sva sva0 (
	.clk_sys,
	.rst_n,
	.reset_req,
	.core_rst_n,
	.ldr_wr,
	.ldr_done
);

`default_nettype wire

//--- verification/x68k_glue_tb.sv
`default_nettype none

module x68k_glue_tb;

	timeunit 1ns;
	timeprecision 1ps;

	// Short LCD hold so the auto mode fits in a quick run
	localparam int HOLD_CYCLES = 20;

	// Signal selectors for wait_level
	localparam int SEL_CORE_RST_N = 0;
	localparam int SEL_IOCTL_WAIT = 1;
	localparam int SEL_LDR_DONE   = 2;

	logic                       clk_sys;
	logic                       rst_n;
	x68k_glue_pkg::status_t     status;
	logic                       user_button;
	logic                       ioctl_download;
	logic                       ioctl_wr;
	logic                       ioctl_wait;
	logic                       ldr_ack;
	logic                       ldr_wr;
	logic                       ldr_aen;
	logic                       ldr_done;
	logic                       core_rst_n;
	x68k_glue_pkg::sample_t     core_l;
	x68k_glue_pkg::sample_t     core_r;
	x68k_glue_pkg::sample_t     mt32_l;
	x68k_glue_pkg::sample_t     mt32_r;
	x68k_glue_pkg::sample_t     audio_l;
	x68k_glue_pkg::sample_t     audio_r;
	logic                       mt32_available;
	logic                       mt32_newmode;
	x68k_glue_pkg::mt32_code_t  mt32_mode;
	x68k_glue_pkg::mt32_code_t  mt32_rom;
	x68k_glue_pkg::mt32_code_t  mt32_sf;
	logic                       lcd_update;
	logic                       lcd_en;
	logic                       lcd_pix;
	logic                       mt32_rst;
	logic                       info_req;
	x68k_glue_pkg::info_code_t  info_disp;
	x68k_glue_pkg::chan_t       red_in;
	x68k_glue_pkg::chan_t       green_in;
	x68k_glue_pkg::chan_t       blue_in;
	x68k_glue_pkg::chan_t       red;
	x68k_glue_pkg::chan_t       green;
	x68k_glue_pkg::chan_t       blue;

	int     n_errors = 0;
	int     n_checks = 0;
	int     cycle_count = 0;
	integer seed = 32'h27bf;

	// Expected results with the cycle they are due in
	int          due_q[$];
	int          kind_q[$];
	logic [31:0] exp_q[$];

	x68k_glue_top #(.LCD_HOLD(HOLD_CYCLES)) dut0 (.*);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
	end

	////////////////////////////////////////////////////////////////////////////
	// Reference models
	////////////////////////////////////////////////////////////////////////////

	// Saturating mix then two-segment compression of one channel
	function automatic logic [15:0] ref_mix_compress(
		input logic signed [15:0] core,
		input logic signed [15:0] synth,
		input bit                 mute,
		input bit                 sel
	);
		int sum;
		int mag;
		int gain;
		int div;
		int knee;
		int res;
		sum = core;
		if (!mute) begin
			sum = sum + synth;
		end
		if (sum > 32767) begin
			sum = 32767;
		end
		if (sum < -32768) begin
			sum = -32768;
		end
		mag  = (sum < 0) ? -sum : sum;
		gain = sel ? 4 : 2;
		div  = sel ? 8 : 4;
		knee = 32767 * (div - 1) / (div * gain - 1) + 1;
		res  = (mag < knee) ? mag * gain : (mag - knee) / div + knee * gain;
		// Curve end is clipped at full scale
		if (res > 32767) begin
			res = 32767;
		end
		if (sum < 0) begin
			res = -res;
		end
		return 16'(res);
	endfunction

	// Menu message index for a synth mode
	function automatic logic [3:0] ref_info_code(
		input logic [7:0] mode,
		input logic [7:0] rom,
		input logic [7:0] sf
	);
		if (mode == 8'hA2) begin
			return 4'(1 + sf);
		end
		if (mode == 8'hA1 && rom < 3) begin
			return 4'(9 + rom);
		end
		return 4'd12;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Checking helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic check_value(
		input string       name,
		input logic [31:0] expected,
		input logic [31:0] actual
	);
		n_checks++;
		if (actual !== expected) begin
			n_errors++;
			$display("error %s expected %h got %h", name, expected, actual);
		end
	endtask

	task automatic report_timeout(input string what);
		n_errors++;
		$display("timed out waiting for %s", what);
	endtask

	function automatic logic probe(input int which);
		case (which)
			SEL_CORE_RST_N: return core_rst_n;
			SEL_IOCTL_WAIT: return ioctl_wait;
			SEL_LDR_DONE:   return ldr_done;
			default:        return 1'bx;
		endcase
	endfunction

	// Polled on falling edges where outputs are settled
	task automatic wait_level(
		input string what,
		input int    which,
		input logic  level,
		input int    limit
	);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (probe(which) !== level && n < limit) begin
			@(negedge clk_sys);
			n++;
		end
		if (probe(which) !== level) begin
			report_timeout(what);
		end
	endtask

	task automatic drain_expected();
		int n;
		n = 0;
		while (due_q.size() != 0 && n < 8) begin
			@(negedge clk_sys);
			n++;
		end
		if (due_q.size() != 0) begin
			report_timeout("queued results to be compared");
			due_q.delete();
			kind_q.delete();
			exp_q.delete();
		end
	endtask

	// Pops every expected value that falls due in this cycle
	always @(negedge clk_sys) begin
		while (due_q.size() != 0 && due_q[0] == cycle_count) begin
			if (kind_q[0] == 0) begin
				check_value("audio", exp_q[0], {audio_l, audio_r});
			end else begin
				check_value("info_disp", exp_q[0], {28'd0, info_disp});
			end
			due_q.delete(0);
			kind_q.delete(0);
			exp_q.delete(0);
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus tasks
	////////////////////////////////////////////////////////////////////////////

	// One host byte, held until the core acknowledges
	task automatic host_byte();
		@(posedge clk_sys);
		ioctl_wr <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		wait_level("ioctl_wait to rise", SEL_IOCTL_WAIT, 1'b1, 4);
		repeat (2) begin
			@(negedge clk_sys);
			check_value("ioctl_wait held", 1, ioctl_wait);
		end
		check_value("ldr_wr pending", 1, ldr_wr);
		@(posedge clk_sys);
		ldr_ack <= 1'b1;
		@(posedge clk_sys);
		ldr_ack <= 1'b0;
		wait_level("ioctl_wait to clear", SEL_IOCTL_WAIT, 1'b0, 4);
	endtask

	// Status changes pass the status register before they take effect
	task automatic set_audio_mode(input bit sel, input bit dis);
		@(posedge clk_sys);
		status[x68k_glue_pkg::ST_COMP_SEL]     <= sel;
		status[x68k_glue_pkg::ST_MT32_DISABLE] <= dis;
		repeat (3) @(posedge clk_sys);
	endtask

	task automatic set_info_mode(input logic [1:0] mode);
		@(posedge clk_sys);
		status[x68k_glue_pkg::ST_INFO_LO +: 2] <= mode;
		repeat (3) @(posedge clk_sys);
	endtask

	// Audio result is due two cycles after the pair is seen
	task automatic send_audio(
		input logic [15:0] c_l,
		input logic [15:0] c_r,
		input logic [15:0] s_l,
		input logic [15:0] s_r,
		input bit          avail,
		input bit          dis,
		input bit          sel
	);
		bit mute;
		mute = avail & dis;
		@(posedge clk_sys);
		core_l         <= c_l;
		core_r         <= c_r;
		mt32_l         <= s_l;
		mt32_r         <= s_r;
		mt32_available <= avail;
		due_q.push_back(cycle_count + 3);
		kind_q.push_back(0);
		exp_q.push_back({ref_mix_compress(c_l, s_l, mute, sel),
			ref_mix_compress(c_r, s_r, mute, sel)});
	endtask

	task automatic audio_burst(input int count, input bit dis, input bit sel);
		logic [31:0] a;
		logic [31:0] b;
		bit          avail;
		repeat (count) begin
			a     = $random(seed);
			b     = $random(seed);
			avail = $random(seed);
			send_audio(a[15:0], a[31:16], b[15:0], b[31:16], avail, dis, sel);
		end
	endtask

	task automatic send_info(
		input logic [7:0] mode,
		input logic [7:0] rom,
		input logic [7:0] sf
	);
		@(posedge clk_sys);
		mt32_mode <= mode;
		mt32_rom  <= rom;
		mt32_sf   <= sf;
		due_q.push_back(cycle_count + 2);
		kind_q.push_back(1);
		exp_q.push_back({28'd0, ref_info_code(mode, rom, sf)});
	endtask

	// Mostly the two known modes, sometimes any byte
	task automatic info_burst(input int count);
		logic [31:0] r;
		logic [7:0]  mode;
		repeat (count) begin
			r = $random(seed);
			case (r[6:5])
				2'd0:    mode = 8'hA1;
				2'd1:    mode = 8'hA2;
				default: mode = r[15:8];
			endcase
			send_info(mode, {6'd0, r[1:0]}, {5'd0, r[4:2]});
		end
	endtask

	task automatic toggle_newmode(input bit pulse);
		@(posedge clk_sys);
		mt32_newmode <= ~mt32_newmode;
		@(negedge clk_sys);
		check_value("info_req before", 0, info_req);
		@(negedge clk_sys);
		check_value("info_req pulse", pulse, info_req);
		@(negedge clk_sys);
		check_value("info_req after", 0, info_req);
	endtask

	task automatic compare_video(input string name, input bit shown);
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
		logic [31:0] p;
		r = $random(seed);
		g = $random(seed);
		b = $random(seed);
		p = $random(seed);
		@(posedge clk_sys);
		red_in   <= r;
		green_in <= g;
		blue_in  <= b;
		lcd_pix  <= p[0];
		@(posedge clk_sys);
		@(negedge clk_sys);
		check_value(name, shown ? {24'd0, p[0], p[0], r[7:2]} : {24'd0, r}, {24'd0, red});
		check_value(name, shown ? {24'd0, p[0], p[0], g[7:2]} : {24'd0, g}, {24'd0, green});
		check_value(name, shown ? {24'd0, p[0], p[0], b[7:2]} : {24'd0, b}, {24'd0, blue});
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int n;
		rst_n          = 1'b0;
		status         = '0;
		user_button    = 1'b0;
		ioctl_download = 1'b0;
		ioctl_wr       = 1'b0;
		ldr_ack        = 1'b0;
		core_l         = '0;
		core_r         = '0;
		mt32_l         = '0;
		mt32_r         = '0;
		mt32_available = 1'b0;
		mt32_newmode   = 1'b0;
		mt32_mode      = '0;
		mt32_rom       = '0;
		mt32_sf        = '0;
		lcd_update     = 1'b0;
		lcd_en         = 1'b0;
		lcd_pix        = 1'b0;
		red_in         = '0;
		green_in       = '0;
		blue_in        = '0;
		repeat (4) @(posedge clk_sys);
		rst_n <= 1'b1;

		// Core held until the menu reset has pulsed and a download starts
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value("core_rst_n before init", 0, core_rst_n);
		@(posedge clk_sys);
		status[x68k_glue_pkg::ST_RESET] <= 1'b1;
		repeat (3) @(posedge clk_sys);
		status[x68k_glue_pkg::ST_RESET] <= 1'b0;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value("core_rst_n before download", 0, core_rst_n);
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		wait_level("core_rst_n to rise", SEL_CORE_RST_N, 1'b1, 6);
		check_value("ldr_aen during download", 1, ldr_aen);

		// Byte exchange, then the loader closes
		repeat (4) host_byte();
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		wait_level("ldr_done to rise", SEL_LDR_DONE, 1'b1, 4);
		check_value("ldr_aen after download", 0, ldr_aen);
		@(posedge clk_sys);
		ioctl_wr <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		repeat (3) begin
			@(negedge clk_sys);
			check_value("ioctl_wait after download", 0, ioctl_wait);
		end
		check_value("core_rst_n running", 1, core_rst_n);

		// Board button resets the core and the synth
		@(posedge clk_sys);
		user_button <= 1'b1;
		wait_level("core_rst_n to fall on the button", SEL_CORE_RST_N, 1'b0, 4);
		check_value("mt32_rst on button", 1, mt32_rst);
		@(posedge clk_sys);
		user_button <= 1'b0;
		wait_level("core_rst_n to rise after the button", SEL_CORE_RST_N, 1'b1, 4);
		check_value("mt32_rst released", 0, mt32_rst);

		// Menu synth reset leaves the core running
		@(posedge clk_sys);
		status[x68k_glue_pkg::ST_MT32_RESET] <= 1'b1;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		check_value("mt32_rst from the menu", 1, mt32_rst);
		check_value("core_rst_n during synth reset", 1, core_rst_n);
		@(posedge clk_sys);
		status[x68k_glue_pkg::ST_MT32_RESET] <= 1'b0;

		// Both curves with full scale and overflowing pairs first
		for (int sel = 0; sel < 2; sel++) begin
			set_audio_mode(sel[0], 1'b0);
			send_audio(16'h7fff, 16'h8000, 16'h7fff, 16'h8000, 1'b1, 1'b0, sel[0]);
			send_audio(16'h8000, 16'h0001, 16'h0000, 16'h7fff, 1'b0, 1'b0, sel[0]);
			audio_burst(40, 1'b0, sel[0]);
			drain_expected();
		end

		// Synth muted by the menu
		set_audio_mode(1'b1, 1'b1);
		send_audio(16'h1234, 16'hc000, 16'h7000, 16'h7000, 1'b1, 1'b1, 1'b1);
		audio_burst(24, 1'b1, 1'b1);
		drain_expected();

		// Info codes
		send_info(8'hA2, 8'd0, 8'd3);
		send_info(8'hA1, 8'd2, 8'd0);
		send_info(8'h5c, 8'd1, 8'd1);
		info_burst(24);
		drain_expected();

		// Info request only on a mode change in the matching policy
		set_info_mode(x68k_glue_pkg::INFO_ON_CHANGE);
		toggle_newmode(1'b1);
		toggle_newmode(1'b1);
		set_info_mode(x68k_glue_pkg::INFO_OFF);
		toggle_newmode(1'b0);
		set_info_mode(x68k_glue_pkg::INFO_LCD_ON);
		toggle_newmode(1'b0);

		// LCD forced on, then masked by lcd_en
		@(posedge clk_sys);
		lcd_en <= 1'b1;
		repeat (8) compare_video("lcd on overlay", 1'b1);
		@(posedge clk_sys);
		lcd_en <= 1'b0;
		repeat (4) compare_video("lcd disabled", 1'b0);

		// Auto mode on a black input where a lit pixel shows as C0
		@(posedge clk_sys);
		lcd_en   <= 1'b1;
		lcd_pix  <= 1'b1;
		red_in   <= 8'h00;
		green_in <= 8'h00;
		blue_in  <= 8'h00;
		set_info_mode(x68k_glue_pkg::INFO_LCD_AUTO);
		@(negedge clk_sys);
		check_value("lcd auto idle", 8'h00, red);
		@(posedge clk_sys);
		lcd_update <= ~lcd_update;
		n = 0;
		@(negedge clk_sys);
		while (red !== 8'hC0 && n < 4) begin
			@(negedge clk_sys);
			n++;
		end
		if (red !== 8'hC0) begin
			report_timeout("the LCD overlay to appear");
		end
		check_value("lcd auto green", 8'hC0, green);
		n = 0;
		while (red !== 8'h00 && n < HOLD_CYCLES + 2) begin
			@(negedge clk_sys);
			n++;
		end
		if (red !== 8'h00) begin
			report_timeout("the LCD overlay to turn off");
		end else if (n < HOLD_CYCLES - 2) begin
			n_errors++;
			$display("LCD overlay turned off too early, after %0d cycles", n);
		end

		// Pass-through with the info display off even after LCD activity
		set_info_mode(x68k_glue_pkg::INFO_LCD_ON);
		set_info_mode(x68k_glue_pkg::INFO_OFF);
		@(posedge clk_sys);
		lcd_update <= ~lcd_update;
		repeat (6) compare_video("info off video", 1'b0);

		drain_expected();
		check_value("loader assertions", 0, dut0.u_loader.sva0.n_fail);
		$display("checks %0d errors %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- x68k_glue.f
source/x68k_glue_pkg.sv
source/x68k_status_regs.sv
source/x68k_reset_loader.sv
source/x68k_audio_mix.sv
source/x68k_mt32_display.sv
source/x68k_glue_top.sv
verification/x68k_glue_sva.sv
verification/x68k_glue_tb.sv
